// File: project.f
+incdir+.
sd_cmd_pkg.sv
cmd_phys_controller.sv
cmd_serializer.sv
cmd_deserializer.sv
sd_cmd_phys.sv
sd_cmd_phys_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run with Verilator, then look for the fail message in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f project.f --top-module sd_cmd_phys_tb \
	-o sd_cmd_phys_sim > sim.log 2>&1 \
	&& ./obj_dir/sd_cmd_phys_sim >> sim.log 2>&1 \
	|| echo "Test failed" >> sim.log
cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0

// File: sd_cmd_phys_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "sd_cmd_params.svh"

module sd_cmd_phys_tb
	import sd_cmd_pkg::*;
();

	localparam int CLOCK_PERIOD = 100;
	localparam int RESET_CYCLES = 5;
	localparam logic [31:0] SEED = 32'hb031f664;
	localparam int NUM_RANDOM = 20;
	localparam int REPLY_DELAY_MIN = 2;
	localparam int REPLY_DELAY_MAX = 40;
	localparam int ACK_DELAY_MAX = 10;
	localparam int CYCLES_PER_TRANSACTION = 400;
	localparam int WATCHDOG_CYCLES = NUM_RANDOM * CYCLES_PER_TRANSACTION;

	logic sd_clock = 1'b0;
	logic reset;
	logic strobe_in;
	logic ack_in;
	logic idle_in;
	logic cmd_in;
	cmd_frame_t command;
	logic strobe_out;
	logic ack_out;
	logic command_timeout;
	logic cmd_out;
	logic cmd_oe;
	response_t response;

	logic [31:0] rng_state = SEED;
	int error_count = 0;
	int check_count = 0;
	int response_count = 0;
	cmd_frame_t sent_frame = '0;  // frame the card should see
	int card_delay = REPLY_DELAY_MIN;
	logic card_silent = 1'b0;
	logic strobe_seen = 1'b0;

	always #(CLOCK_PERIOD / 2) sd_clock = ~sd_clock;

	sd_cmd_phys i_sd_cmd_phys (
		.sd_clock(sd_clock),
		.reset(reset),
		.strobe_in(strobe_in),
		.ack_in(ack_in),
		.idle_in(idle_in),
		.command(command),
		.strobe_out(strobe_out),
		.ack_out(ack_out),
		.response(response),
		.command_timeout(command_timeout),
		.cmd_in(cmd_in),
		.cmd_out(cmd_out),
		.cmd_oe(cmd_oe)
	);

	function automatic logic [31:0] next_random();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	function automatic int random_range(input int low, input int high);
		logic [31:0] r;
		r = next_random();
		return low + int'(r % 32'(high - low + 1));
	endfunction

	function automatic cmd_frame_t random_frame();
		logic [31:0] high_word;
		logic [31:0] low_word;
		cmd_frame_t frame;
		high_word = next_random();
		low_word = next_random();
		frame = {high_word, low_word[15:0]};
		frame[47] = 1'b0;  // start bit
		frame[46] = 1'b1;  // host to card
		frame[0] = 1'b1;  // end bit
		return frame;
	endfunction

	// start 0, inverted frame, frame, then the command index repeated
	function automatic response_t expected_response(input cmd_frame_t frame);
		logic [5:0] index;
		logic [41:0] fill;
		index = frame[45:40];
		fill = {7{index}};
		return {1'b0, ~frame, frame, fill[38:0]};
	endfunction

	task automatic check_value(input string name, input response_t expected,
		input response_t actual);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic issue_command(input cmd_frame_t frame);
		@(posedge sd_clock);
		sent_frame = frame;
		command <= frame;
		strobe_in <= 1'b1;
		@(posedge sd_clock);
		strobe_in <= 1'b0;  // one cycle request
	endtask

	task automatic check_idle(input string name);
		check_value({name, " strobe_out"}, response_t'(1'b0), response_t'(strobe_out));
		check_value({name, " ack_out"}, response_t'(1'b0), response_t'(ack_out));
		check_value({name, " cmd_oe"}, response_t'(1'b0), response_t'(cmd_oe));
		check_value({name, " timeout"}, response_t'(1'b0), response_t'(command_timeout));
		check_value({name, " response"}, '0, response);
	endtask

	task automatic run_transaction(input cmd_frame_t frame, input int reply_delay,
		input int ack_delay);
		response_t expected;
		int i;
		expected = expected_response(frame);
		card_silent = 1'b0;
		card_delay = reply_delay;
		issue_command(frame);
		@(negedge sd_clock);
		while (!strobe_out)
			@(negedge sd_clock);
		// response must not move while the host holds off
		for (i = 0; i < ack_delay; i++)
		begin
			@(negedge sd_clock);
			check_value("held strobe_out", response_t'(1'b1), response_t'(strobe_out));
			check_value("held response", expected, response);
			check_value("ack_out before ack", response_t'(1'b0), response_t'(ack_out));
		end
		@(posedge sd_clock);
		ack_in <= 1'b1;
		@(negedge sd_clock);
		check_value("ack_out with ack", response_t'(1'b1), response_t'(ack_out));
		check_value("strobe_out with ack", response_t'(1'b1), response_t'(strobe_out));
		@(posedge sd_clock);
		ack_in <= 1'b0;
		@(negedge sd_clock);
		check_idle("after ack");
	endtask

	task automatic run_silent_command(input cmd_frame_t frame);
		int cycles;
		card_silent = 1'b1;
		issue_command(frame);
		@(negedge sd_clock);
		while (cmd_oe)
			@(negedge sd_clock);
		cycles = 0;  // first cycle of the turnaround
		while (!command_timeout)
		begin
			@(negedge sd_clock);
			cycles++;
		end
		check_value("timeout cycles", response_t'(`SD_TIMEOUT_LIMIT), response_t'(cycles));
		repeat (30)
		begin
			@(negedge sd_clock);
			check_value("timeout held", response_t'(1'b1), response_t'(command_timeout));
			check_value("no strobe while silent", response_t'(1'b0), response_t'(strobe_out));
		end
		@(posedge sd_clock);
		idle_in <= 1'b1;
		@(posedge sd_clock);
		idle_in <= 1'b0;
		repeat (2)
			@(negedge sd_clock);  // counter clears one cycle after leaving
		check_idle("after abort");
		card_silent = 1'b0;
	endtask

	// card model captures the frame and answers after a delay
	initial
	begin
		cmd_frame_t captured;
		response_t reply;
		int oe_cycles;
		int i;
		cmd_in <= 1'b1;
		forever
		begin
			@(negedge sd_clock);
			if (cmd_oe)
			begin
				oe_cycles = 0;
				captured = '0;
				while (cmd_oe)
				begin
					if (oe_cycles == 0)
						check_value("line high in load", response_t'(1'b1), response_t'(cmd_out));
					else
						captured = {captured[`SD_CMD_BITS-2:0], cmd_out};
					oe_cycles++;
					@(negedge sd_clock);
				end
				check_value("cmd_oe cycles", response_t'(`SD_CMD_BITS + 1),
					response_t'(oe_cycles));
				check_value("command bits", response_t'(sent_frame), response_t'(captured));
				if (!card_silent)
				begin
					reply = expected_response(captured);
					repeat (card_delay)
						@(posedge sd_clock);
					for (i = 0; i < `SD_RESP_BITS; i++)
					begin
						cmd_in <= reply[`SD_RESP_BITS-1];
						reply = reply << 1;
						@(posedge sd_clock);
					end
					cmd_in <= 1'b1;
				end
			end
		end
	end

	// compare the response on every rising strobe
	always @(negedge sd_clock)
	begin
		if (strobe_out && !strobe_seen)
		begin
			check_value("response at strobe", expected_response(sent_frame), response);
			response_count++;
		end
		strobe_seen = strobe_out;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLOCK_PERIOD);
		$display("watchdog expired after %0d cycles, the DUT appears to be hung",
			WATCHDOG_CYCLES);
		$display("checks: %0d, errors: %0d", check_count, error_count);
		$display("Test failed");
		$finish;
	end

	initial
	begin
		cmd_frame_t frame;
		int reply_delay;
		int ack_delay;
		int n;
		reset <= 1'b1;
		strobe_in <= 1'b0;
		ack_in <= 1'b0;
		idle_in <= 1'b0;
		command <= '0;
		repeat (RESET_CYCLES)
			@(posedge sd_clock);
		reset <= 1'b0;
		repeat (3)
		begin
			@(negedge sd_clock);
			check_idle("after reset");
		end
		run_transaction(48'h42_0000_0000_4d, REPLY_DELAY_MIN, 0);  // CMD2
		run_silent_command(random_frame());
		run_transaction(48'h49_1234_0000_01, REPLY_DELAY_MAX, ACK_DELAY_MAX);  // CMD9
		for (n = 0; n < NUM_RANDOM; n++)
		begin
			frame = random_frame();
			reply_delay = random_range(REPLY_DELAY_MIN, REPLY_DELAY_MAX);
			ack_delay = random_range(0, ACK_DELAY_MAX);
			run_transaction(frame, reply_delay, ack_delay);
		end
		check_value("responses seen", response_t'(NUM_RANDOM + 2), response_t'(response_count));
		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: sd_cmd_phys.sv
`timescale 1ns/1ps
`default_nettype none

module sd_cmd_phys
	import sd_cmd_pkg::*;
(
	input wire logic sd_clock,
	input wire logic reset,
	// host
	input wire logic strobe_in,
	input wire logic ack_in,
	input wire logic idle_in,
	input wire cmd_frame_t command,
	output logic strobe_out,
	output logic ack_out,
	output response_t response,
	output logic command_timeout,
	// card pad
	input wire logic cmd_in,
	output logic cmd_out,
	output logic cmd_oe
);

	wrapper_ctrl_t wrapper;
	logic transmission_complete;
	logic reception_complete;
	logic serial_bit;
	response_t pad_response;

	cmd_phys_controller i_controller (
		.sd_clock(sd_clock),
		.reset(reset),
		.strobe_in(strobe_in),
		.ack_in(ack_in),
		.idle_in(idle_in),
		.ack_out(ack_out),
		.strobe_out(strobe_out),
		.response(response),
		.command_timeout(command_timeout),
		.transmission_complete(transmission_complete),
		.reception_complete(reception_complete),
		.pad_response(pad_response),
		.wrapper(wrapper)
	);

	cmd_serializer i_serializer (
		.sd_clock(sd_clock),
		.reset(reset),
		.clear(wrapper.reset_wrapper),
		.enable(wrapper.enable_pts),
		.shift(wrapper.load_send),
		.command(command),
		.serial_out(serial_bit),
		.transmission_complete(transmission_complete)
	);

	cmd_deserializer i_deserializer (
		.sd_clock(sd_clock),
		.reset(reset),
		.clear(wrapper.reset_wrapper),
		.enable(wrapper.enable_stp),
		.serial_in(cmd_in),
		.pad_response(pad_response),
		.reception_complete(reception_complete)
	);

	assign cmd_oe = wrapper.pad_state & wrapper.pad_enable;
	assign cmd_out = wrapper.load_send ? serial_bit : 1'b1;  // high outside the shift

endmodule

`default_nettype wire

// File: cmd_deserializer.sv
`timescale 1ns/1ps
`default_nettype none

`include "sd_cmd_params.svh"

module cmd_deserializer
	import sd_cmd_pkg::*;
(
	input wire logic sd_clock,
	input wire logic reset,
	input wire logic clear,
	input wire logic enable,
	input wire logic serial_in,
	output response_t pad_response,
	output logic reception_complete
);

	typedef enum logic [1:0]
	{
		HUNT,
		COLLECT,
		HOLD
	} rx_state_t;

	rx_state_t rx_state;
	resp_bit_idx_t bit_count;  // bits taken so far
	response_t shift_reg;
	logic start_bit;
	logic take_bit;
	logic last_bit;

	assign start_bit = (rx_state == HUNT) && enable && !serial_in;
	assign take_bit = start_bit || (rx_state == COLLECT);
	assign last_bit = (rx_state == COLLECT) &&
		(bit_count == resp_bit_idx_t'(`SD_RESP_BITS - 1));

	always_ff @(posedge sd_clock)
	begin
		if (reset || clear)
		begin
			rx_state <= HUNT;
			bit_count <= '0;
		end
		else
		begin
			case (rx_state)
			HUNT:
			begin
				if (start_bit)
				begin
					rx_state <= COLLECT;
					bit_count <= resp_bit_idx_t'(1);  // start bit counts
				end
			end
			COLLECT:
			begin
				bit_count <= bit_count + 1'b1;
				if (last_bit)
					rx_state <= HOLD;
			end
			default:
				rx_state <= HOLD;  // keep the response until cleared
			endcase
		end
	end

	always_ff @(posedge sd_clock)
	begin
		if (clear)
			shift_reg <= '0;
		else if (take_bit)
			shift_reg <= {shift_reg[`SD_RESP_BITS-2:0], serial_in};
	end

	assign pad_response = shift_reg;
	assign reception_complete = last_bit;  // with the final bit on the line

endmodule

`default_nettype wire

// File: cmd_serializer.sv
`timescale 1ns/1ps
`default_nettype none

`include "sd_cmd_params.svh"

module cmd_serializer
	import sd_cmd_pkg::*;
(
	input wire logic sd_clock,
	input wire logic reset,
	input wire logic clear,
	input wire logic enable,
	input wire logic shift,
	input wire cmd_frame_t command,
	output logic serial_out,
	output logic transmission_complete
);

	cmd_frame_t shift_reg;
	cmd_bit_idx_t bits_left;
	logic busy;  // frame loaded with bits still to go
	logic load;
	logic last_bit;

	assign load = enable && !shift;
	assign last_bit = shift && busy && (bits_left == '0);

	always_ff @(posedge sd_clock)
	begin
		if (clear)
			shift_reg <= '1;
		else if (load)
			shift_reg <= command;
		else if (shift)
			shift_reg <= {shift_reg[`SD_CMD_BITS-2:0], 1'b1};  // msb first
	end

	always_ff @(posedge sd_clock)
	begin
		if (reset || clear)
		begin
			busy <= 1'b0;
			bits_left <= '0;
		end
		else if (load)
		begin
			busy <= 1'b1;
			bits_left <= cmd_bit_idx_t'(`SD_CMD_BITS - 1);
		end
		else if (shift && busy)
		begin
			if (last_bit)
				busy <= 1'b0;
			else
				bits_left <= bits_left - 1'b1;
		end
	end

	// line idles high when nothing is going out
	assign serial_out = (shift && busy) ? shift_reg[`SD_CMD_BITS-1] : 1'b1;
	assign transmission_complete = last_bit;

endmodule

`default_nettype wire

// File: cmd_phys_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "sd_cmd_params.svh"

module cmd_phys_controller
	import sd_cmd_pkg::*;
(
	input wire logic sd_clock,
	input wire logic reset,
	// host side
	input wire logic strobe_in,  // request
	input wire logic ack_in,
	input wire logic idle_in,  // abort to idle
	output logic ack_out,
	output logic strobe_out,  // response valid level
	output response_t response,
	output logic command_timeout,
	// wrapper side
	input wire logic transmission_complete,
	input wire logic reception_complete,
	input wire response_t pad_response,
	output wrapper_ctrl_t wrapper
);

	cmd_state_t state;
	cmd_state_t next_state;

	logic loaded;
	logic response_sent;
	timeout_cnt_t timeout_count;
	logic delay_count;

	always_ff @(posedge sd_clock)
	begin
		if (reset)
			state <= RESET;
		else if (idle_in)
			state <= IDLE;
		else
			state <= next_state;
	end

	// both counters only run while waiting for the card
	always_ff @(posedge sd_clock)
	begin
		if (reset || state != WAIT_RESPONSE)
		begin
			timeout_count <= '0;
			delay_count <= 1'b0;
		end
		else
		begin
			if (!command_timeout)
				timeout_count <= timeout_count + 1'b1;  // saturates at the limit
			delay_count <= 1'b1;
		end
	end

	assign command_timeout = (timeout_count == timeout_cnt_t'(`SD_TIMEOUT_LIMIT));

	always_comb
	begin
		ack_out = 1'b0;
		strobe_out = 1'b0;
		response = '0;
		loaded = 1'b0;
		response_sent = 1'b0;
		wrapper = '0;
		next_state = state;
		case (state)
		RESET:
		begin
			wrapper.reset_wrapper = 1'b1;
			next_state = IDLE;
		end
		IDLE:
		begin
			wrapper.reset_wrapper = 1'b1;
			if (strobe_in)
				next_state = LOAD_COMMAND;
		end
		LOAD_COMMAND:
		begin
			loaded = 1'b1;
			wrapper.pad_state = 1'b1;
			wrapper.pad_enable = 1'b1;
			wrapper.enable_pts = 1'b1;  // serializer latches the frame
			if (loaded)
				next_state = SEND_COMMAND;
		end
		SEND_COMMAND:
		begin
			loaded = 1'b1;
			wrapper.pad_state = 1'b1;
			wrapper.pad_enable = 1'b1;
			wrapper.enable_pts = 1'b1;
			wrapper.load_send = 1'b1;
			if (transmission_complete)
				next_state = WAIT_RESPONSE;
		end
		WAIT_RESPONSE:
		begin
			loaded = 1'b1;
			wrapper.pad_enable = 1'b1;  // line turned around so the pad is not driven
			// one cycle of turnaround before hunting for the start bit
			wrapper.enable_stp = delay_count;
			if (reception_complete)
				next_state = SEND_RESPONSE;
		end
		SEND_RESPONSE:
		begin
			strobe_out = 1'b1;
			response = pad_response;
			response_sent = 1'b1;
			if (response_sent)
				next_state = WAIT_ACK;
		end
		WAIT_ACK:
		begin
			strobe_out = 1'b1;
			response = pad_response;
			ack_out = ack_in;
			if (ack_out)
				next_state = IDLE;
		end
		default:
		begin
			wrapper.reset_wrapper = 1'b1;
			next_state = RESET;
		end
		endcase
	end

endmodule

`default_nettype wire

// File: sd_cmd_pkg.sv
`default_nettype none

`include "sd_cmd_params.svh"

package sd_cmd_pkg;

	typedef logic [`SD_CMD_BITS-1:0] cmd_frame_t;
	typedef logic [`SD_RESP_BITS-1:0] response_t;  // start bit at the msb

	typedef logic [`SD_TIMEOUT_BITS-1:0] timeout_cnt_t;
	typedef logic [$clog2(`SD_CMD_BITS)-1:0] cmd_bit_idx_t;
	typedef logic [$clog2(`SD_RESP_BITS)-1:0] resp_bit_idx_t;

	typedef enum logic [3:0]
	{
		RESET = 4'd0,
		IDLE = 4'd1,
		LOAD_COMMAND = 4'd2,
		SEND_COMMAND = 4'd3,
		WAIT_RESPONSE = 4'd4,
		SEND_RESPONSE = 4'd5,
		WAIT_ACK = 4'd6
	} cmd_state_t;

	// controller to serializer and deserializer
	typedef struct packed
	{
		logic reset_wrapper;  // empties both wrapper blocks
		logic pad_state;
		logic pad_enable;
		logic enable_pts;  // parallel to serial
		logic enable_stp;  // serial to parallel
		logic load_send;  // shift the frame out
	} wrapper_ctrl_t;

endpackage

`default_nettype wire

// File: sd_cmd_params.svh
`ifndef SD_CMD_PARAMS_SVH
`define SD_CMD_PARAMS_SVH

// command frame on the CMD line including start and end bits
`define SD_CMD_BITS 48

// long response with the start bit counted
`define SD_RESP_BITS 136

// cycles in WAIT_RESPONSE before the timeout level rises
`define SD_TIMEOUT_LIMIT 63

// wide enough to hold the limit
`define SD_TIMEOUT_BITS 7

`endif
